/* src/mrv1_pkg.sv */
package mrv1_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Hardware threads
    localparam int NUM_TW    = 4;
    localparam int TWID_W    = 2;

    // Datapath and register file
    localparam int DATA_W    = 32;
    localparam int RF_ADDR_W = 5;

    // Issue tag wraps at eight
    localparam int ITAG_W    = 3;

    // LDI immediate before sign extension
    localparam int IMM_W     = 16;

    // Retired instruction count
    localparam int CNT_W     = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Plain vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [TWID_W-1:0]    twid_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;
    typedef logic [ITAG_W-1:0]    itag_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [CNT_W-1:0]     cnt_t;

    // ALU operations, encoding as seen by the instruction source
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        LDI = 3'd7
    } alu_op_e;

    // Issue FSM
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        STALL = 2'd2
    } issue_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline records
    ////////////////////////////////////////////////////////////////////////////

    // Decoded instruction at the core input
    typedef struct packed {
        twid_t    twid;
        alu_op_e  op;
        rf_addr_t rd;
        rf_addr_t rs0;
        rf_addr_t rs1;
        imm_t     imm;
    } insn_t;

    // Issued instruction with its operands read
    typedef struct packed {
        logic     vld;
        twid_t    twid;
        alu_op_e  op;
        rf_addr_t rd;
        itag_t    itag;
        data_t    src0;
        data_t    src1;
    } exec_req_t;

    // Completed instruction, ALU stage and retire stage
    typedef struct packed {
        logic     vld;
        twid_t    twid;
        rf_addr_t rd;
        itag_t    itag;
        data_t    data;
    } retire_t;

endpackage

/* src/mrv1_tag_counter.sv */
`timescale 1ns/1ps

module mrv1_tag_counter (
    input  logic            clk_i,
    input  logic            rst_down_w,
    input  logic            issue_i,
    input  logic            retire_i,
    output mrv1_pkg::itag_t itag_o,
    output mrv1_pkg::cnt_t  retire_cnt_o
);
    import mrv1_pkg::*;

    itag_t itag_q;
    cnt_t  cnt_q;

    // Issue tag, wraps at eight on its own
    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            itag_q <= '0;
        end else if (issue_i) begin
            itag_q <= itag_q + itag_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Retired count
    ////////////////////////////////////////////////////////////////////////////

    // Holds at all ones
    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            cnt_q <= '0;
        end else if (retire_i && (cnt_q != '1)) begin
            cnt_q <= cnt_q + cnt_t'(1);
        end
    end

    assign itag_o       = itag_q;
    assign retire_cnt_o = cnt_q;

endmodule

/* src/mrv1_issue_ctrl.sv */
`timescale 1ns/1ps

module mrv1_issue_ctrl (
    input  logic                clk_i,
    input  logic                rst_down_w,
    input  logic                fetch_en_i,
    input  logic                insn_vld_i,
    input  mrv1_pkg::insn_t     insn_i,
    input  mrv1_pkg::itag_t     itag_i,
    input  mrv1_pkg::data_t     rf_rs0_data_i,
    input  mrv1_pkg::data_t     rf_rs1_data_i,
    input  mrv1_pkg::retire_t   alu_stage_i,
    input  mrv1_pkg::retire_t   ret_stage_i,
    output logic                insn_rdy_o,
    output logic                accept_o,
    output mrv1_pkg::twid_t     rf_twid_o,
    output mrv1_pkg::rf_addr_t  rf_rs0_addr_o,
    output mrv1_pkg::rf_addr_t  rf_rs1_addr_o,
    output mrv1_pkg::exec_req_t exec_req_o
);
    import mrv1_pkg::*;

    issue_state_e state_q;
    issue_state_e state_d;
    logic         src_vld;
    logic         hazard;
    data_t        imm_ext;

    // Pending write in a stage that the RF does not hold yet
    function automatic logic stage_match(input retire_t stg, input twid_t twid,
                                         input rf_addr_t rs);
        stage_match = stg.vld && (stg.twid == twid) && (stg.rd != '0) && (stg.rd == rs);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Hazard check
    ////////////////////////////////////////////////////////////////////////////

    // LDI reads no register
    assign src_vld = (insn_i.op != LDI);

    // Either source against ALU stage or retire stage
    assign hazard = src_vld &&
                    (stage_match(alu_stage_i, insn_i.twid, insn_i.rs0) ||
                     stage_match(alu_stage_i, insn_i.twid, insn_i.rs1) ||
                     stage_match(ret_stage_i, insn_i.twid, insn_i.rs0) ||
                     stage_match(ret_stage_i, insn_i.twid, insn_i.rs1));

    ////////////////////////////////////////////////////////////////////////////
    // Issue FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fetch_en_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (!fetch_en_i) begin
                    state_d = IDLE;
                end else if (insn_vld_i && hazard) begin
                    state_d = STALL;
                end
            end
            STALL: begin
                // Clears once the producer has been written back
                if (!fetch_en_i) begin
                    state_d = IDLE;
                end else if (!hazard) begin
                    state_d = RUN;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Ready only when enabled and the sources are clean
    assign insn_rdy_o = (state_q != IDLE) && fetch_en_i && !hazard;
    assign accept_o   = insn_vld_i && insn_rdy_o;

    ////////////////////////////////////////////////////////////////////////////
    // Operand read
    ////////////////////////////////////////////////////////////////////////////

    assign rf_twid_o     = insn_i.twid;
    assign rf_rs0_addr_o = insn_i.rs0;
    assign rf_rs1_addr_o = insn_i.rs1;

    // Sign extended immediate
    assign imm_ext = {{(DATA_W-IMM_W){insn_i.imm[IMM_W-1]}}, insn_i.imm};

    always_comb begin
        exec_req_o.vld  = accept_o;
        exec_req_o.twid = insn_i.twid;
        exec_req_o.op   = insn_i.op;
        exec_req_o.rd   = insn_i.rd;
        exec_req_o.itag = itag_i;
        exec_req_o.src0 = rf_rs0_data_i;
        // LDI carries its immediate in src1
        exec_req_o.src1 = (insn_i.op == LDI) ? imm_ext : rf_rs1_data_i;
    end

endmodule

/* src/mrv1_rf.sv */
`timescale 1ns/1ps

module mrv1_rf (
    input  logic               clk_i,
    input  logic               rst_down_w,
    input  mrv1_pkg::twid_t    rd_twid_i,
    input  mrv1_pkg::rf_addr_t rs0_addr_i,
    input  mrv1_pkg::rf_addr_t rs1_addr_i,
    input  logic               w_en_i,
    input  mrv1_pkg::twid_t    w_twid_i,
    input  mrv1_pkg::rf_addr_t w_addr_i,
    input  mrv1_pkg::data_t    w_data_i,
    output mrv1_pkg::data_t    rs0_data_o,
    output mrv1_pkg::data_t    rs1_data_o
);
    import mrv1_pkg::*;

    localparam int NUM_REGS = 2 ** RF_ADDR_W;

    // One bank per thread
    data_t regs_q [NUM_TW][NUM_REGS];

    ////////////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            for (int t = 0; t < NUM_TW; t++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs_q[t][r] <= '0;
                end
            end
        end else if (w_en_i && (w_addr_i != '0)) begin
            // x0 stays zero
            regs_q[w_twid_i][w_addr_i] <= w_data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////////////////////

    // Both reads use the issuing thread
    assign rs0_data_o = (rs0_addr_i == '0) ? '0 : regs_q[rd_twid_i][rs0_addr_i];
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rd_twid_i][rs1_addr_i];

endmodule

/* src/mrv1_alu.sv */
`timescale 1ns/1ps

module mrv1_alu (
    input  logic                clk_i,
    input  logic                rst_down_w,
    input  mrv1_pkg::exec_req_t exec_req_i,
    output mrv1_pkg::retire_t   alu_stage_o
);
    import mrv1_pkg::*;

    exec_req_t req_q;
    data_t     result;
    logic [4:0] shamt;

    ////////////////////////////////////////////////////////////////////////////
    // Execute stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            req_q.vld <= 1'b0;
        end else begin
            req_q.vld <= exec_req_i.vld;
        end
    end

    // Payload loads only with a new request
    always_ff @(posedge clk_i) begin
        if (exec_req_i.vld) begin
            req_q.twid <= exec_req_i.twid;
            req_q.op   <= exec_req_i.op;
            req_q.rd   <= exec_req_i.rd;
            req_q.itag <= exec_req_i.itag;
            req_q.src0 <= exec_req_i.src0;
            req_q.src1 <= exec_req_i.src1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////

    // Shift amount from low bits of src1
    assign shamt = req_q.src1[4:0];

    always_comb begin
        case (req_q.op)
            ADD:     result = req_q.src0 + req_q.src1;
            SUB:     result = req_q.src0 - req_q.src1;
            AND:     result = req_q.src0 & req_q.src1;
            OR:      result = req_q.src0 | req_q.src1;
            XOR:     result = req_q.src0 ^ req_q.src1;
            SLL:     result = req_q.src0 << shamt;
            // Logical, zero fill
            SRL:     result = req_q.src0 >> shamt;
            LDI:     result = req_q.src1;
            default: result = '0;
        endcase
    end

    always_comb begin
        alu_stage_o.vld  = req_q.vld;
        alu_stage_o.twid = req_q.twid;
        alu_stage_o.rd   = req_q.rd;
        alu_stage_o.itag = req_q.itag;
        alu_stage_o.data = result;
    end

endmodule

/* src/mrv1_retire.sv */
`timescale 1ns/1ps

module mrv1_retire (
    input  logic               clk_i,
    input  logic               rst_down_w,
    input  mrv1_pkg::retire_t  alu_stage_i,
    output mrv1_pkg::retire_t  retire_o,
    output logic               rf_w_en_o,
    output mrv1_pkg::twid_t    rf_w_twid_o,
    output mrv1_pkg::rf_addr_t rf_w_addr_o,
    output mrv1_pkg::data_t    rf_w_data_o
);
    import mrv1_pkg::*;

    retire_t ret_q;

    ////////////////////////////////////////////////////////////////////////////
    // Retire register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_down_w) begin
            ret_q.vld <= 1'b0;
        end else begin
            ret_q.vld <= alu_stage_i.vld;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alu_stage_i.vld) begin
            ret_q.twid <= alu_stage_i.twid;
            ret_q.rd   <= alu_stage_i.rd;
            ret_q.itag <= alu_stage_i.itag;
            ret_q.data <= alu_stage_i.data;
        end
    end

    // Every completed instruction is reported, x0 included
    assign retire_o = ret_q;

    ////////////////////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////////////////////

    // No write for rd zero
    assign rf_w_en_o   = ret_q.vld && (ret_q.rd != '0);
    assign rf_w_twid_o = ret_q.twid;
    assign rf_w_addr_o = ret_q.rd;
    assign rf_w_data_o = ret_q.data;

endmodule

/* src/mrv1_core.sv */
`timescale 1ns/1ps

module mrv1_core (
    input  logic              clk_i,
    input  logic              rst_down_w,
    input  logic              fetch_en_i,
    input  logic              insn_vld_i,
    input  mrv1_pkg::insn_t   insn_i,
    output logic              insn_rdy_o,
    output mrv1_pkg::retire_t retire_o,
    output mrv1_pkg::cnt_t    retire_cnt_o
);
    import mrv1_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Issue
    ////////////////////////////////////////////////////////////////////////////

    logic      accept_w;
    itag_t     itag_w;
    twid_t     rf_twid_w;
    rf_addr_t  rf_rs0_addr_w;
    rf_addr_t  rf_rs1_addr_w;
    data_t     rf_rs0_data_w;
    data_t     rf_rs1_data_w;
    exec_req_t exec_req_w;

    // Stage records fed back for the hazard check
    retire_t   alu_stage_w;

    // Writeback
    logic      rf_w_en_w;
    twid_t     rf_w_twid_w;
    rf_addr_t  rf_w_addr_w;
    data_t     rf_w_data_w;

    mrv1_issue_ctrl issue0 (
        .clk_i         (clk_i),
        .rst_down_w    (rst_down_w),
        .fetch_en_i    (fetch_en_i),
        .insn_vld_i    (insn_vld_i),
        .insn_i        (insn_i),
        .itag_i        (itag_w),
        .rf_rs0_data_i (rf_rs0_data_w),
        .rf_rs1_data_i (rf_rs1_data_w),
        .alu_stage_i   (alu_stage_w),
        .ret_stage_i   (retire_o),
        .insn_rdy_o    (insn_rdy_o),
        .accept_o      (accept_w),
        .rf_twid_o     (rf_twid_w),
        .rf_rs0_addr_o (rf_rs0_addr_w),
        .rf_rs1_addr_o (rf_rs1_addr_w),
        .exec_req_o    (exec_req_w)
    );

    mrv1_tag_counter tag0 (
        .clk_i        (clk_i),
        .rst_down_w   (rst_down_w),
        .issue_i      (accept_w),
        .retire_i     (retire_o.vld),
        .itag_o       (itag_w),
        .retire_cnt_o (retire_cnt_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Register file, execute and retire
    ////////////////////////////////////////////////////////////////////////////

    mrv1_rf rf0 (
        .clk_i      (clk_i),
        .rst_down_w (rst_down_w),
        .rd_twid_i  (rf_twid_w),
        .rs0_addr_i (rf_rs0_addr_w),
        .rs1_addr_i (rf_rs1_addr_w),
        .w_en_i     (rf_w_en_w),
        .w_twid_i   (rf_w_twid_w),
        .w_addr_i   (rf_w_addr_w),
        .w_data_i   (rf_w_data_w),
        .rs0_data_o (rf_rs0_data_w),
        .rs1_data_o (rf_rs1_data_w)
    );

    mrv1_alu alu0 (
        .clk_i       (clk_i),
        .rst_down_w  (rst_down_w),
        .exec_req_i  (exec_req_w),
        .alu_stage_o (alu_stage_w)
    );

    mrv1_retire ret0 (
        .clk_i       (clk_i),
        .rst_down_w  (rst_down_w),
        .alu_stage_i (alu_stage_w),
        .retire_o    (retire_o),
        .rf_w_en_o   (rf_w_en_w),
        .rf_w_twid_o (rf_w_twid_w),
        .rf_w_addr_o (rf_w_addr_w),
        .rf_w_data_o (rf_w_data_w)
    );

endmodule

/* sim/mrv1_core_properties.sv */
`timescale 1ns/1ps

module mrv1_core_properties (
    input logic              clk_i,
    input logic              rst_down_w,
    input logic              fetch_en_i,
    input logic              insn_vld_i,
    input logic              insn_rdy_o,
    input mrv1_pkg::retire_t retire_o,
    input mrv1_pkg::cnt_t    retire_cnt_o
);

    // Input handshake
    logic accept_w;
    assign accept_w = insn_vld_i && insn_rdy_o;

    // Issue stays idle for the cycle after fetch was disabled
    rdy_off_a: assert property (
        @(posedge clk_i) disable iff (rst_down_w)
        !fetch_en_i |=> !insn_rdy_o
    ) else $error("insn_rdy_o high in the cycle after fetch_en_i was low");

    // Each retire traces back to an accept two edges earlier
    retire_src_a: assert property (
        @(posedge clk_i) disable iff (rst_down_w)
        retire_o.vld |-> $past(accept_w, 2)
    ) else $error("retire_o.vld without a matching acceptance");

    // Count is monotonic
    cnt_mono_a: assert property (
        @(posedge clk_i) disable iff (rst_down_w)
        retire_cnt_o >= $past(retire_cnt_o)
    ) else $error("retire_cnt_o decreased");

endmodule

bind mrv1_core mrv1_core_properties props0 (.*);

/* sim/mrv1_core_tb.sv */
`timescale 1ns/1ps

module mrv1_core_tb;
    import mrv1_pkg::*;

    // Stimulus file layout
    localparam int NUM_OPS        = 28;
    localparam int STIM_COLS      = 7;

    // Run control
    localparam int RESET_CYC      = 10;
    localparam int TIMEOUT_CYC    = RESET_CYC + 4 * NUM_OPS + 20;
    localparam int DRIVE_DLY      = 1;

    // Fetch disabled before this line is offered
    localparam int FETCH_OFF_LINE = 13;
    localparam int FETCH_OFF_CYC  = 4;

    logic    clk_i;
    logic    rst_down_w;
    logic    fetch_en_i;
    logic    insn_vld_i;
    insn_t   insn_i;
    logic    insn_rdy_o;
    retire_t retire_o;
    cnt_t    retire_cnt_o;

    // One word per column with seven per instruction
    logic [31:0] stim_mem [STIM_COLS*NUM_OPS];

    // Expected retires in acceptance order
    retire_t     exp_q [$];
    retire_t     head_r;
    int          accept_cnt;
    int          cycle_cnt = 0;
    integer      seed;

    mrv1_core dut0 (
        .clk_i        (clk_i),
        .rst_down_w   (rst_down_w),
        .fetch_en_i   (fetch_en_i),
        .insn_vld_i   (insn_vld_i),
        .insn_i       (insn_i),
        .insn_rdy_o   (insn_rdy_o),
        .retire_o     (retire_o),
        .retire_cnt_o (retire_cnt_o)
    );

    // 100 ns period
    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Test failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Unpack one stimulus line
    task automatic load_insn(input int line, output insn_t insn, output data_t data);
        int base;
        base      = line * STIM_COLS;
        insn.twid = twid_t'(stim_mem[base]);
        insn.op   = alu_op_e'(stim_mem[base + 1][2:0]);
        insn.rd   = rf_addr_t'(stim_mem[base + 2]);
        insn.rs0  = rf_addr_t'(stim_mem[base + 3]);
        insn.rs1  = rf_addr_t'(stim_mem[base + 4]);
        insn.imm  = imm_t'(stim_mem[base + 5]);
        data      = stim_mem[base + 6];
    endtask

    task automatic record_accept(input insn_t insn, input data_t data);
        retire_t exp_r;
        exp_r.vld  = 1'b1;
        exp_r.twid = insn.twid;
        exp_r.rd   = insn.rd;
        // Tags run modulo eight
        exp_r.itag = itag_t'(accept_cnt % 8);
        exp_r.data = data;
        exp_q.push_back(exp_r);
        accept_cnt++;
    endtask

    // Offer a line with fetch off while ready stays low
    task automatic pause_fetch(input int line);
        insn_t insn;
        data_t data;
        load_insn(line, insn, data);
        fetch_en_i = 1'b0;
        insn_i     = insn;
        insn_vld_i = 1'b1;
        repeat (FETCH_OFF_CYC) begin
            @(negedge clk_i);
            check_value("insn_rdy_o", 32'(insn_rdy_o), 32'd0);
            @(posedge clk_i);
            #(DRIVE_DLY);
        end
        fetch_en_i = 1'b1;
    endtask

    // Offer one line and hold it until accepted
    task automatic issue_line(input int line, input bit allow_gap);
        insn_t insn;
        data_t data;
        bit    taken;
        load_insn(line, insn, data);
        // Occasional idle cycle before a fresh instruction
        if (allow_gap && (($random(seed) & 3) == 0)) begin
            insn_vld_i = 1'b0;
            @(posedge clk_i);
            #(DRIVE_DLY);
        end
        insn_i     = insn;
        insn_vld_i = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            // Inputs have settled so ready holds until the edge
            @(negedge clk_i);
            taken = insn_rdy_o;
            @(posedge clk_i);
            if (taken) begin
                record_accept(insn, data);
            end
            #(DRIVE_DLY);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Retire checker
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (!rst_down_w && retire_o.vld) begin
            if (exp_q.size() == 0) begin
                $display("Retire seen with no accepted instruction outstanding");
                $display("Test failed");
                $fatal(1, "Unexpected retire");
            end else begin
                head_r = exp_q.pop_front();
                check_value("retire_o.twid", 32'(retire_o.twid), 32'(head_r.twid));
                check_value("retire_o.rd", 32'(retire_o.rd), 32'(head_r.rd));
                check_value("retire_o.itag", 32'(retire_o.itag), 32'(head_r.itag));
                check_value("retire_o.data", retire_o.data, head_r.data);
            end
        end
    end

    // Watchdog
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions accepted",
                     cycle_cnt, accept_cnt, NUM_OPS);
            $display("Test failed");
            $fatal(1, "Simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed       = 14729;
        accept_cnt = 0;
        rst_down_w = 1'b1;
        fetch_en_i = 1'b0;
        insn_vld_i = 1'b0;
        insn_i     = '0;
        $readmemh("sim/stim_ops.txt", stim_mem);

        repeat (RESET_CYC) @(posedge clk_i);
        #(DRIVE_DLY);
        rst_down_w = 1'b0;

        // Post reset state
        @(negedge clk_i);
        check_value("insn_rdy_o", 32'(insn_rdy_o), 32'd0);
        check_value("retire_o.vld", 32'(retire_o.vld), 32'd0);
        check_value("retire_cnt_o", 32'(retire_cnt_o), 32'd0);
        @(posedge clk_i);
        #(DRIVE_DLY);
        fetch_en_i = 1'b1;

        for (int line = 0; line < NUM_OPS; line++) begin
            if (line == FETCH_OFF_LINE) begin
                pause_fetch(line);
            end
            issue_line(line, line != FETCH_OFF_LINE);
        end
        insn_vld_i = 1'b0;

        // Drain and let the count settle
        while (exp_q.size() != 0) @(posedge clk_i);
        @(negedge clk_i);
        check_value("retire_cnt_o", 32'(retire_cnt_o), 32'(NUM_OPS));

        if (retire_o.vld) begin
            $display("Extra retire seen after the last expected one at end of run");
            $display("Test failed");
            $fatal(1, "End of run check");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* sim/stim_ops.txt */
// Columns in hex: twid op rd rs0 rs1 imm expected_retire_data
// op: 0 ADD, 1 SUB, 2 AND, 3 OR, 4 XOR, 5 SLL, 6 SRL, 7 LDI
0 7 01 00 00 1234 00001234
0 7 02 00 00 fff0 fffffff0
0 0 03 01 02 0000 00001224
1 7 01 00 00 7fff 00007fff
1 7 02 00 00 0004 00000004
0 1 04 01 02 0000 00001244
1 5 03 01 02 0000 0007fff0
1 6 04 03 02 0000 00007fff
0 2 05 03 04 0000 00001204
0 3 06 03 04 0000 00001264
0 4 07 03 04 0000 00000060
2 7 00 00 00 5555 00005555
2 0 01 00 00 0000 00000000
2 7 01 00 00 8000 ffff8000
2 7 03 00 00 001f 0000001f
2 6 02 01 03 0000 00000001
3 7 01 00 00 0001 00000001
3 5 02 01 01 0000 00000002
3 1 03 00 01 0000 ffffffff
1 4 01 01 03 0000 0007800f
0 0 01 01 00 0000 00001234
3 0 04 03 02 0000 00000001
2 3 05 01 02 0000 ffff8001
1 0 00 01 04 0000 0008000e
1 1 05 00 04 0000 ffff8001
0 5 02 06 07 0000 00001264
3 2 05 04 03 0000 00000001
0 1 03 01 01 0000 00000000

/* flist.f */
src/mrv1_pkg.sv
src/mrv1_tag_counter.sv
src/mrv1_issue_ctrl.sv
src/mrv1_rf.sv
src/mrv1_alu.sv
src/mrv1_retire.sv
src/mrv1_core.sv
sim/mrv1_core_properties.sv
sim/mrv1_core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module mrv1_core_tb -o mrv1_sim \
    && ./obj_dir/mrv1_sim \
    || { echo "Simulation run did not pass"; exit 1; }
